//--- include/ecfg_rx_regmap.svh
`ifndef ECFG_RX_REGMAP_SVH
`define ECFG_RX_REGMAP_SVH

// register indices inside the rx config group
// index = mi_addr[RFAW+1:2], word aligned

// rx enable, mmu enable, remap mode/sel/pattern, timer cfg
`define ELRXCFG   0

// synchronized gpio frame/data pins, read only
`define ELRXGPIO  1

// dynamic remap base
`define ELRXBASE  2

// sticky debug bits, read only
`define ELRXDEBUG 3

`endif

//--- design/erx_cfg_pkg.sv
package erx_cfg_pkg;

   // ############################
   // widths
   // ############################
   localparam int MI_AW   = 20;   // mi byte address
   localparam int MI_DW   = 32;   // mi data word
   localparam int RX_AW   = 32;   // receive address
   localparam int RX_DW   = 32;   // receive data
   localparam int GPIO_W  = 9;    // frame + 8 data pins
   localparam int DBG_W   = 3;    // sticky debug bits
   localparam int REMAP_W = 12;   // remapped upper address bits 31:20

   // debug bit positions
   localparam int DBG_DROP    = 0;   // txn dropped, rx disabled
   localparam int DBG_STATIC  = 1;   // static remap applied
   localparam int DBG_DYNAMIC = 2;   // dynamic remap applied

   // ############################
   // remap mode encoding
   // ############################
   typedef enum logic [1:0] {
      remap_none    = 2'b00,
      remap_static  = 2'b01,
      remap_dynamic = 2'b10,
      remap_off     = 2'b11    // behaves as none
   } remap_mode_t;

   // config fields that steer the remapper
   typedef struct packed {
      logic               rx_enable;
      remap_mode_t        remap_mode;
      logic [REMAP_W-1:0] remap_sel;       // mask over addr 31:20
      logic [REMAP_W-1:0] remap_pattern;   // replacement bits
      logic [RX_AW-1:0]   remap_base;      // added in dynamic mode
   } rx_cfg_t;

endpackage

//--- design/mi_bus_if.sv
`timescale 1ns/1ps

// simple memory interface, one cycle per access, no handshake
interface mi_bus_if
   import erx_cfg_pkg::*;
();

   logic             mi_en;     // access strobe
   logic             mi_we;     // write when high, read otherwise
   logic [MI_AW-1:0] mi_addr;   // full byte address, group in 19:16
   logic [MI_DW-1:0] mi_din;    // write data
   logic [MI_DW-1:0] mi_dout;   // read data, one cycle after the read

   // bus side driving accesses
   modport master (
      output mi_en,
      output mi_we,
      output mi_addr,
      output mi_din,
      input  mi_dout
   );

   // register file side
   modport slave (
      input  mi_en,
      input  mi_we,
      input  mi_addr,
      input  mi_din,
      output mi_dout
   );

endinterface

//--- design/ecfg_rx.sv
`timescale 1ns/1ps
`include "ecfg_rx_regmap.svh"

module ecfg_rx
   import erx_cfg_pkg::*;
#(
   parameter int         RFAW  = 5,      // register index width
   parameter logic [3:0] GROUP = 4'h0    // group id, mi_addr[19:16]
)
(
   input  logic              mi_clk,
   input  logic              reset,
   mi_bus_if.slave           mi,
   input  logic [GPIO_W-1:0] gpio_datain,   // async pins
   input  logic [DBG_W-1:0]  debug_event,   // pulses from remapper
   output rx_cfg_t           rx_cfg,
   output logic              mmu_enable,
   output logic [1:0]        timer_cfg
);

   logic              group_hit;
   logic              ecfg_write;
   logic              ecfg_read;
   logic [RFAW-1:0]   reg_idx;
   logic [MI_DW-1:0]  ecfg_rx_reg;     // rx config word
   logic [MI_DW-1:0]  ecfg_base_reg;   // dynamic remap base
   logic [GPIO_W-1:0] gpio_sync;       // first sync stage
   logic [GPIO_W-1:0] gpio_reg;        // second stage, readable
   logic [DBG_W-1:0]  debug_reg;       // sticky events
   logic [MI_DW-1:0]  rd_data;

   // ############################
   // address decode
   // ############################
   // bit 15 low selects the rx half of the group
   assign group_hit  = (mi.mi_addr[19:15] == {GROUP, 1'b0});
   assign ecfg_write = mi.mi_en &  mi.mi_we & group_hit;
   assign ecfg_read  = mi.mi_en & ~mi.mi_we & group_hit;
   assign reg_idx    = mi.mi_addr[RFAW+1:2];   // word index

   // ############################
   // rx config
   // ############################
   always_ff @(posedge mi_clk)
   begin
      if (reset)
         ecfg_rx_reg <= '0;
      else if (ecfg_write && (reg_idx == RFAW'(`ELRXCFG)))
         ecfg_rx_reg <= mi.mi_din;   // visible next cycle
   end

   // field split
   assign rx_cfg.rx_enable     = ecfg_rx_reg[0];
   assign mmu_enable           = ecfg_rx_reg[1];
   assign rx_cfg.remap_mode    = remap_mode_t'(ecfg_rx_reg[3:2]);
   assign rx_cfg.remap_sel     = ecfg_rx_reg[15:4];
   assign rx_cfg.remap_pattern = ecfg_rx_reg[27:16];
   assign timer_cfg            = ecfg_rx_reg[29:28];   // 00 = timeout off

   // dynamic remap base
   always_ff @(posedge mi_clk)
   begin
      if (reset)
         ecfg_base_reg <= '0;
      else if (ecfg_write && (reg_idx == RFAW'(`ELRXBASE)))
         ecfg_base_reg <= mi.mi_din;
   end

   assign rx_cfg.remap_base = ecfg_base_reg;

   // ############################
   // gpio sync + sticky debug
   // ############################
   // two flops, value readable two clocks after the pins
   always_ff @(posedge mi_clk)
   begin
      if (reset)
      begin
         gpio_sync <= '0;
         gpio_reg  <= '0;
      end
      else
      begin
         gpio_sync <= gpio_datain;
         gpio_reg  <= gpio_sync;
      end
   end

   // events only set bits, cleared by reset alone
   always_ff @(posedge mi_clk)
   begin
      if (reset)
         debug_reg <= '0;
      else
         debug_reg <= debug_reg | debug_event;
   end

   // ############################
   // readback
   // ############################
   always_comb
   begin
      case (reg_idx)
         RFAW'(`ELRXCFG):   rd_data = ecfg_rx_reg;
         RFAW'(`ELRXGPIO):  rd_data = {{(MI_DW-GPIO_W){1'b0}}, gpio_reg};
         RFAW'(`ELRXBASE):  rd_data = ecfg_base_reg;
         RFAW'(`ELRXDEBUG): rd_data = {{(MI_DW-DBG_W){1'b0}}, debug_reg};
         default:           rd_data = '0;   // unmapped
      endcase
   end

   // pipelined, holds until the next read hit
   always_ff @(posedge mi_clk)
   begin
      if (reset)
         mi.mi_dout <= '0;
      else if (ecfg_read)
         mi.mi_dout <= rd_data;
   end

endmodule

//--- design/erx_remap.sv
`timescale 1ns/1ps

module erx_remap
   import erx_cfg_pkg::*;
(
   input  logic             mi_clk,
   input  logic             reset,
   input  rx_cfg_t          rx_cfg,
   input  logic             rx_valid_in,
   input  logic [RX_AW-1:0] rx_addr_in,
   input  logic [RX_DW-1:0] rx_data_in,
   output logic             rx_valid_out,   // one cycle after rx_valid_in
   output logic [RX_AW-1:0] rx_addr_out,
   output logic [RX_DW-1:0] rx_data_out,
   output logic [DBG_W-1:0] debug_event     // registered pulses
);

   logic [REMAP_W-1:0] addr_hi;        // incoming bits 31:20
   logic [RX_AW-1:0]   addr_static;
   logic [RX_AW-1:0]   addr_dynamic;
   logic [RX_AW-1:0]   addr_next;
   logic               accept;         // valid and rx enabled
   logic               drop;           // valid while rx disabled
   logic [DBG_W-1:0]   debug_next;

   // ############################
   // remap select
   // ############################
   assign addr_hi = rx_addr_in[RX_AW-1 -: REMAP_W];

   // pattern where sel is set, own bit elsewhere
   assign addr_static = {(rx_cfg.remap_sel & rx_cfg.remap_pattern) |
                         (~rx_cfg.remap_sel & addr_hi),
                         rx_addr_in[RX_AW-REMAP_W-1:0]};

   assign addr_dynamic = rx_addr_in + rx_cfg.remap_base;   // wraps at 2^32

   always_comb
   begin
      case (rx_cfg.remap_mode)
         remap_static:  addr_next = addr_static;
         remap_dynamic: addr_next = addr_dynamic;
         default:       addr_next = rx_addr_in;   // none and off
      endcase
   end

   // ############################
   // gating + debug events
   // ############################
   assign accept = rx_valid_in &  rx_cfg.rx_enable;
   assign drop   = rx_valid_in & ~rx_cfg.rx_enable;

   always_comb
   begin
      debug_next              = '0;
      debug_next[DBG_DROP]    = drop;
      debug_next[DBG_STATIC]  = accept & (rx_cfg.remap_mode == remap_static);
      debug_next[DBG_DYNAMIC] = accept & (rx_cfg.remap_mode == remap_dynamic);
   end

   // ############################
   // output stage
   // ############################
   always_ff @(posedge mi_clk)
   begin
      if (reset)
      begin
         rx_valid_out <= 1'b0;
         debug_event  <= '0;
      end
      else
      begin
         rx_valid_out <= accept;       // dropped txns never show up
         debug_event  <= debug_next;   // aligned with the output
      end
   end

   // payload follows an accepted txn, no reset
   always_ff @(posedge mi_clk)
   begin
      if (accept)
      begin
         rx_addr_out <= addr_next;
         rx_data_out <= rx_data_in;    // data untouched
      end
   end

endmodule

//--- design/erx_cfg_top.sv
`timescale 1ns/1ps

module erx_cfg_top
   import erx_cfg_pkg::*;
#(
   parameter int         RFAW  = 5,     // register index width
   parameter logic [3:0] GROUP = 4'h0   // config group id
)
(
   input  logic              mi_clk,
   input  logic              reset,
   // simple memory interface
   input  logic              mi_en,
   input  logic              mi_we,
   input  logic [MI_AW-1:0]  mi_addr,
   input  logic [MI_DW-1:0]  mi_din,
   output logic [MI_DW-1:0]  mi_dout,
   // gpio pins
   input  logic [GPIO_W-1:0] gpio_datain,
   // receive path in
   input  logic              rx_valid_in,
   input  logic [RX_AW-1:0]  rx_addr_in,
   input  logic [RX_DW-1:0]  rx_data_in,
   // receive path out, remapped
   output logic              rx_valid_out,
   output logic [RX_AW-1:0]  rx_addr_out,
   output logic [RX_DW-1:0]  rx_data_out,
   // exported config, used outside this block
   output logic              mmu_enable,
   output logic [1:0]        timer_cfg
);

   rx_cfg_t          rx_cfg;        // reg file -> remapper
   logic [DBG_W-1:0] debug_event;   // remapper -> sticky bits

   // ############################
   // mi bus
   // ############################
   mi_bus_if mi ();

   assign mi.mi_en   = mi_en;
   assign mi.mi_we   = mi_we;
   assign mi.mi_addr = mi_addr;
   assign mi.mi_din  = mi_din;
   assign mi_dout    = mi.mi_dout;

   // register file
   ecfg_rx #(
      .RFAW  (RFAW),
      .GROUP (GROUP)
   ) u_ecfg_rx (
      .mi_clk      (mi_clk),
      .reset       (reset),
      .mi          (mi.slave),
      .gpio_datain (gpio_datain),
      .debug_event (debug_event),
      .rx_cfg      (rx_cfg),
      .mmu_enable  (mmu_enable),
      .timer_cfg   (timer_cfg)
   );

   // address remapper
   erx_remap u_erx_remap (
      .mi_clk       (mi_clk),
      .reset        (reset),
      .rx_cfg       (rx_cfg),
      .rx_valid_in  (rx_valid_in),
      .rx_addr_in   (rx_addr_in),
      .rx_data_in   (rx_data_in),
      .rx_valid_out (rx_valid_out),
      .rx_addr_out  (rx_addr_out),
      .rx_data_out  (rx_data_out),
      .debug_event  (debug_event)
   );

endmodule

//--- verification/erx_cfg_asserts.sv
`timescale 1ns/1ps

module erx_cfg_asserts
(
   input logic mi_clk,
   input logic reset,
   input logic rx_enable,
   input logic rx_valid_in,
   input logic rx_valid_out
);

   logic accept;   // txn that must come out

   assign accept = rx_valid_in & rx_enable;

   // ############################
   // reset
   // ############################
   reset_clears_valid: assert property (@(posedge mi_clk) reset |=> !rx_valid_out)
      else $error("rx_valid_out high after a reset cycle");

   // ############################
   // one cycle latency
   // ############################
   accept_gives_valid: assert property (
      @(posedge mi_clk) disable iff (reset) accept |=> rx_valid_out)
      else $error("accepted txn missing on rx_valid_out one cycle later");

   // dropped or idle cycles never show up
   idle_gives_no_valid: assert property (
      @(posedge mi_clk) disable iff (reset) !accept |=> !rx_valid_out)
      else $error("rx_valid_out high without an accepted txn the cycle before");

endmodule

bind erx_remap erx_cfg_asserts u_erx_cfg_asserts (
   .mi_clk       (mi_clk),
   .reset        (reset),
   .rx_enable    (rx_cfg.rx_enable),
   .rx_valid_in  (rx_valid_in),
   .rx_valid_out (rx_valid_out)
);

//--- verification/erx_cfg_tb.sv
`timescale 1ns/1ps
`include "ecfg_rx_regmap.svh"

module erx_cfg_tb
   import erx_cfg_pkg::*;
();

   localparam int MAX_CYCLES   = 2000;   // whole run needs a few hundred
   localparam int TXN_PER_MODE = 8;

   logic              mi_clk;
   logic              reset;
   logic              mi_en;
   logic              mi_we;
   logic [MI_AW-1:0]  mi_addr;
   logic [MI_DW-1:0]  mi_din;
   logic [MI_DW-1:0]  mi_dout;
   logic [GPIO_W-1:0] gpio_datain;
   logic              rx_valid_in;
   logic [RX_AW-1:0]  rx_addr_in;
   logic [RX_DW-1:0]  rx_data_in;
   logic              rx_valid_out;
   logic [RX_AW-1:0]  rx_addr_out;
   logic [RX_DW-1:0]  rx_data_out;
   logic              mmu_enable;
   logic [1:0]        timer_cfg;

   integer seed;
   integer errors;
   integer checks;
   integer test_errors;   // error count when the current test started
   integer cycles = 0;

   erx_cfg_top #(
      .RFAW  (5),
      .GROUP (4'h0)
   ) UUT (
      .mi_clk       (mi_clk),
      .reset        (reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .gpio_datain  (gpio_datain),
      .rx_valid_in  (rx_valid_in),
      .rx_addr_in   (rx_addr_in),
      .rx_data_in   (rx_data_in),
      .rx_valid_out (rx_valid_out),
      .rx_addr_out  (rx_addr_out),
      .rx_data_out  (rx_data_out),
      .mmu_enable   (mmu_enable),
      .timer_cfg    (timer_cfg)
   );

   // ############################
   // clock + timeout
   // ############################
   initial mi_clk = 1'b0;
   always #2 mi_clk = ~mi_clk;   // 4 ns period

   always @(posedge mi_clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   // ############################
   // helpers
   // ############################
   // group in 19:16, bit 15 low, word index from bit 2
   function automatic logic [MI_AW-1:0] reg_addr(input logic [3:0] group, input int idx);
      return {group, 1'b0, 13'(idx), 2'b00};
   endfunction

   function automatic logic [31:0] cfg_word(input logic en, input logic mmu,
         input logic [1:0] mode, input logic [11:0] sel, input logic [11:0] pat,
         input logic [1:0] timer);
      return {2'b00, timer, pat, sel, mode, mmu, en};
   endfunction

   // expected address after remap
   function automatic logic [31:0] remap_ref(input logic [31:0] addr, input logic [1:0] mode,
         input logic [11:0] sel, input logic [11:0] pat, input logic [31:0] base);
      logic [31:0] result;
      result = addr;   // none and off
      if (mode == 2'b01)
         result[31:20] = (addr[31:20] & ~sel) | (pat & sel);
      else if (mode == 2'b10)
         result = addr + base;   // wraps
      return result;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
         input logic [31:0] exp);
      checks = checks + 1;
      if (got !== exp)
      begin
         errors = errors + 1;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      if (errors == test_errors)
         $display("%s: pass", name);
      else
         $display("%s: fail, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   task automatic bus_write(input logic [MI_AW-1:0] addr, input logic [MI_DW-1:0] data);
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= addr;
      mi_din  <= data;
      @(posedge mi_clk);   // write lands on this edge
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
   endtask

   task automatic bus_read(input logic [MI_AW-1:0] addr, output logic [MI_DW-1:0] data);
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= addr;
      @(posedge mi_clk);
      mi_en   <= 1'b0;
      @(negedge mi_clk);   // dout registered one cycle after the read
      data = mi_dout;
   endtask

   // ############################
   // tests
   // ############################
   task automatic reset_defaults();
      logic [31:0] data;
      @(negedge mi_clk);   // no read issued yet
      compare_word("mi_dout", mi_dout, 32'h0);
      bus_read(reg_addr(4'h0, `ELRXCFG), data);
      compare_word("mi_dout ELRXCFG", data, 32'h0);
      bus_read(reg_addr(4'h0, `ELRXBASE), data);
      compare_word("mi_dout ELRXBASE", data, 32'h0);
      bus_read(reg_addr(4'h0, `ELRXDEBUG), data);
      compare_word("mi_dout ELRXDEBUG", data, 32'h0);
      compare_word("mmu_enable", {31'h0, mmu_enable}, 32'h0);
      compare_word("timer_cfg", {30'h0, timer_cfg}, 32'h0);
      compare_word("rx_valid_out", {31'h0, rx_valid_out}, 32'h0);
      report_test("test 1 reset defaults");
   endtask

   task automatic register_access();
      logic [31:0] cfg;
      logic [31:0] base;
      logic [31:0] data;
      cfg  = $random(seed);
      cfg[31:30] = 2'b00;   // no field there
      base = $random(seed);
      bus_write(reg_addr(4'h0, `ELRXCFG), cfg);
      bus_write(reg_addr(4'h0, `ELRXBASE), base);
      bus_read(reg_addr(4'h0, `ELRXCFG), data);
      compare_word("mi_dout ELRXCFG", data, cfg);
      bus_read(reg_addr(4'h0, `ELRXBASE), data);
      compare_word("mi_dout ELRXBASE", data, base);
      compare_word("mmu_enable", {31'h0, mmu_enable}, {31'h0, cfg[1]});
      compare_word("timer_cfg", {30'h0, timer_cfg}, {30'h0, cfg[29:28]});
      bus_read(reg_addr(4'h0, 7), data);   // unmapped index
      compare_word("mi_dout unmapped", data, 32'h0);
      // other group, then rx group with bit 15 set
      bus_write(reg_addr(4'h1, `ELRXCFG), ~cfg);
      bus_write(reg_addr(4'h0, `ELRXBASE) | 20'h08000, ~base);
      bus_read(reg_addr(4'h0, `ELRXCFG), data);
      compare_word("mi_dout ELRXCFG after miss", data, cfg);
      bus_read(reg_addr(4'h0, `ELRXBASE), data);
      compare_word("mi_dout ELRXBASE after miss", data, base);
      report_test("test 2 register access");
   endtask

   task automatic gpio_readback();
      logic [31:0] rnd;
      logic [31:0] data;
      int i;
      for (i = 0; i < 4; i++)
      begin
         rnd = $random(seed);
         @(posedge mi_clk);
         gpio_datain <= rnd[8:0];
         repeat (2) @(posedge mi_clk);   // two sync flops
         bus_read(reg_addr(4'h0, `ELRXGPIO), data);
         compare_word("mi_dout ELRXGPIO", data, {23'h0, rnd[8:0]});
      end
      report_test("test 3 gpio readback");
   endtask

   task automatic remap_modes();
      logic [1:0]  mode;
      logic [11:0] sel;
      logic [11:0] pat;
      logic [31:0] base;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp_addr [$];
      logic [31:0] exp_data [$];
      int m;
      int i;
      for (m = 0; m < 4; m++)
      begin
         mode = 2'(m);   // none, static, dynamic, off
         addr = $random(seed);
         sel  = addr[11:0];
         pat  = addr[23:12];
         base = $random(seed);
         bus_write(reg_addr(4'h0, `ELRXBASE), base);
         bus_write(reg_addr(4'h0, `ELRXCFG), cfg_word(1'b1, 1'b0, mode, sel, pat, 2'b00));
         for (i = 0; i <= TXN_PER_MODE; i++)
         begin
            @(posedge mi_clk);
            if (i < TXN_PER_MODE)
            begin
               addr = $random(seed);
               data = $random(seed);
               rx_valid_in <= 1'b1;   // back to back
               rx_addr_in  <= addr;
               rx_data_in  <= data;
               exp_addr.push_back(remap_ref(addr, mode, sel, pat, base));
               exp_data.push_back(data);
            end
            else
               rx_valid_in <= 1'b0;
            @(negedge mi_clk);
            if (i > 0)   // previous txn is on the output now
            begin
               compare_word("rx_valid_out", {31'h0, rx_valid_out}, 32'h1);
               compare_word("rx_addr_out", rx_addr_out, exp_addr.pop_front());
               compare_word("rx_data_out", rx_data_out, exp_data.pop_front());
            end
         end
      end
      report_test("test 4 remap modes");
   endtask

   task automatic drop_and_debug();
      logic [31:0] rnd;
      logic [31:0] data;
      int i;
      // static and dynamic traffic already seen
      bus_read(reg_addr(4'h0, `ELRXDEBUG), data);
      compare_word("mi_dout ELRXDEBUG", data, 32'h6);
      bus_write(reg_addr(4'h0, `ELRXCFG), cfg_word(1'b0, 1'b0, 2'b01, 12'hfff, 12'h5a5, 2'b00));
      for (i = 0; i <= 4; i++)
      begin
         @(posedge mi_clk);
         rnd = $random(seed);
         rx_valid_in <= (i < 4);
         rx_addr_in  <= rnd;
         rx_data_in  <= ~rnd;
         @(negedge mi_clk);
         compare_word("rx_valid_out", {31'h0, rx_valid_out}, 32'h0);   // all dropped
      end
      @(posedge mi_clk);
      rx_valid_in <= 1'b0;
      repeat (2) @(posedge mi_clk);   // event pulse, then sticky bit
      bus_read(reg_addr(4'h0, `ELRXDEBUG), data);
      compare_word("mi_dout ELRXDEBUG", data, 32'h7);
      repeat (20) @(posedge mi_clk);   // idle, bits stay
      bus_read(reg_addr(4'h0, `ELRXDEBUG), data);
      compare_word("mi_dout ELRXDEBUG idle", data, 32'h7);
      report_test("test 5 drop and debug");
   endtask

   // ############################
   // main
   // ############################
   initial
   begin
      seed        = 99;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      reset       = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      gpio_datain = '0;
      rx_valid_in = 1'b0;
      rx_addr_in  = '0;
      rx_data_in  = '0;
      repeat (4) @(posedge mi_clk);
      reset <= 1'b0;
      reset_defaults();
      register_access();
      gpio_readback();
      remap_modes();
      drop_and_debug();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- erx_cfg_top.f
+incdir+include
design/erx_cfg_pkg.sv
design/mi_bus_if.sv
design/ecfg_rx.sv
design/erx_remap.sv
design/erx_cfg_top.sv
verification/erx_cfg_asserts.sv
verification/erx_cfg_tb.sv

//--- Makefile
# Verilator build for the rx config block and its testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = erx_cfg_tb
FILELIST  = erx_cfg_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
